/* Makefile */
# spi command port, verilator flow

TOP = tb_spi_cmd
LOG = sim.log

.PHONY: all run lint clean

all: run

# build, run, then look for the pass line in the log
run:
	verilator --binary --timescale 1ns/10ps -f project.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -F -q "*** TEST PASSED ***" $(LOG)

lint:
	verilator --lint-only -Wall --timescale 1ns/10ps +incdir+include \
		hw/spi_cmd_pkg.sv hw/spi_byte_if.sv hw/reg_access_if.sv hw/spi_slave.sv \
		hw/spi_cmd_decoder.sv hw/reg_bank.sv hw/spi_cmd_top.sv --top-module spi_cmd_top

clean:
	rm -rf obj_dir $(LOG)

/* hw/reg_access_if.sv */
`timescale 1ns/10ps

interface reg_access_if;
   import spi_cmd_pkg::*;

   // single-cycle register write
   logic      wr_en;
   reg_addr_t wr_addr;
   spi_byte_t wr_data;
   // combinational read port
   reg_addr_t rd_addr;
   spi_byte_t rd_data;
   // one pulse per completed message
   logic      msg_done;

   modport master (
      output wr_en, wr_addr, wr_data, rd_addr, msg_done,
      input  rd_data
   );

   modport bank (
      input  wr_en, wr_addr, wr_data, rd_addr, msg_done,
      output rd_data
   );

endinterface

/* hw/reg_bank.sv */
`timescale 1ns/10ps
`include "spi_cmd_settings.svh"

module reg_bank (
   input  logic        clk,
   input  logic        rst_n,
   reg_access_if.bank  acc,
   output logic [63:0] cfg_regs,
   output logic        cfg_update
);
   import spi_cmd_pkg::*;

   spi_byte_t regs_q [`SPI_NUM_REGS];
   logic      wr_ok;
   logic      update_q;

   // counter slot ignores writes
   assign wr_ok = acc.wr_en && (acc.wr_addr != `SPI_STATUS_ADDR);

   //////////////////////////////////////////////////
   // register storage
   //////////////////////////////////////////////////

   // seven config bytes plus the message counter
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `SPI_NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else begin
         if (wr_ok) begin
            regs_q[acc.wr_addr] <= acc.wr_data;
         end
         // completed messages mod 256
         if (acc.msg_done) begin
            regs_q[`SPI_STATUS_ADDR] <= regs_q[`SPI_STATUS_ADDR] + spi_byte_t'(1);
         end
      end
   end

   // one pulse per accepted write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         update_q <= 1'b0;
      end else begin
         update_q <= wr_ok;
      end
   end

   assign cfg_update = update_q;

   //////////////////////////////////////////////////
   // read and output mapping
   //////////////////////////////////////////////////

   assign acc.rd_data = regs_q[acc.rd_addr];

   // register i in bits 8i+7..8i
   always_comb begin
      for (int i = 0; i < `SPI_NUM_REGS; i++) begin
         cfg_regs[8*i +: 8] = regs_q[i];
      end
   end

endmodule

/* hw/spi_byte_if.sv */
`timescale 1ns/10ps

interface spi_byte_if;
   import spi_cmd_pkg::*;

   // byte 0 of a message is done
   logic      cmd_ready;
   // any later byte is done
   logic      param_ready;
   // received byte, valid with the strobes
   spi_byte_t rx_data;
   // bytes received so far in this message
   byte_cnt_t byte_cnt;
   // synchronized ssel edges
   logic      start_msg;
   logic      end_msg;
   // next reply byte from the decoder
   spi_byte_t tx_data;

   modport slave (
      output cmd_ready, param_ready, rx_data, byte_cnt, start_msg, end_msg,
      input  tx_data
   );

   modport decoder (
      input  cmd_ready, param_ready, rx_data, byte_cnt, start_msg, end_msg,
      output tx_data
   );

endinterface

/* hw/spi_cmd_decoder.sv */
`timescale 1ns/10ps
`include "spi_cmd_settings.svh"

module spi_cmd_decoder (
   input  logic          clk,
   input  logic          rst_n,
   spi_byte_if.decoder   byt,
   reg_access_if.master  acc
);
   import spi_cmd_pkg::*;

   cmd_state_t state;
   reg_addr_t  ptr;
   spi_byte_t  tx_q;
   logic       wr_en_q;
   reg_addr_t  wr_addr_q;
   spi_byte_t  wr_data_q;
   logic       done_q;
   logic [3:0] opcode;
   logic       param_ok;

   assign opcode = byt.rx_data[7:4];

   // bytes past the counter limit are not processed
   assign param_ok = byt.param_ready && (byt.byte_cnt != '1);

   //////////////////////////////////////////////////
   // command fsm
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= ST_IDLE;
         ptr     <= '0;
         tx_q    <= `SPI_IDLE_BYTE;
         wr_en_q <= 1'b0;
         done_q  <= 1'b0;
      end else begin
         // strobes default low
         wr_en_q <= 1'b0;
         done_q  <= byt.end_msg;

         if (byt.start_msg || byt.end_msg) begin
            state <= ST_IDLE;
            tx_q  <= `SPI_IDLE_BYTE;
         end else if (byt.cmd_ready) begin
            // start register from the low bits
            ptr <= byt.rx_data[2:0];
            // reply byte 1 is not ready yet
            tx_q <= `SPI_IDLE_BYTE;
            if (opcode == `SPI_OP_WRITE) begin
               state <= ST_WRITE;
            end else if (opcode == `SPI_OP_READ) begin
               state <= ST_READ;
            end else begin
               state <= ST_SKIP;
            end
         end else if (param_ok) begin
            case (state)
               ST_WRITE: begin
                  // status address still goes out, bank drops it
                  wr_en_q <= 1'b1;
                  ptr     <= ptr + reg_addr_t'(1);
                  tx_q    <= `SPI_IDLE_BYTE;
               end
               ST_READ: begin
                  // goes out on the byte after next
                  tx_q <= acc.rd_data;
                  ptr  <= ptr + reg_addr_t'(1);
               end
               default: begin
                  tx_q <= `SPI_IDLE_BYTE;
               end
            endcase
         end
      end
   end

   // write payload, captured with the strobe
   always_ff @(posedge clk) begin
      if (param_ok && (state == ST_WRITE) && !byt.cmd_ready
          && !byt.start_msg && !byt.end_msg) begin
         wr_addr_q <= ptr;
         wr_data_q <= byt.rx_data;
      end
   end

   //////////////////////////////////////////////////
   // outputs
   //////////////////////////////////////////////////

   assign byt.tx_data  = tx_q;
   assign acc.wr_en    = wr_en_q;
   assign acc.wr_addr  = wr_addr_q;
   assign acc.wr_data  = wr_data_q;
   // read port follows the pointer
   assign acc.rd_addr  = ptr;
   assign acc.msg_done = done_q;

endmodule

/* hw/spi_cmd_pkg.sv */
`include "spi_cmd_settings.svh"

package spi_cmd_pkg;

   //////////////////////////////////////////////////
   // data widths
   //////////////////////////////////////////////////

   // one spi byte
   typedef logic [7:0] spi_byte_t;

   // register address
   // command low bits select the start register
   typedef logic [$clog2(`SPI_NUM_REGS)-1:0] reg_addr_t;

   // number of bytes seen in the current message
   typedef logic [`SPI_BYTE_CNT_W-1:0] byte_cnt_t;

   //////////////////////////////////////////////////
   // decoder fsm
   //////////////////////////////////////////////////

   // idle until a command byte arrives
   // skip holds for unknown opcodes until ssel rises
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_WRITE = 2'd1,
      ST_READ  = 2'd2,
      ST_SKIP  = 2'd3
   } cmd_state_t;

endpackage

/* hw/spi_cmd_top.sv */
`timescale 1ns/10ps

module spi_cmd_top (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        sck,
   input  logic        mosi,
   input  logic        ssel,
   output logic        miso,
   output logic [63:0] cfg_regs,
   output logic        cfg_update
);

   // slave to decoder
   spi_byte_if   byt_if ();
   // decoder to register bank
   reg_access_if acc_if ();

   // pins in, bytes out
   spi_slave u_slave (
      .clk   (clk),
      .rst_n (rst_n),
      .sck   (sck),
      .mosi  (mosi),
      .ssel  (ssel),
      .miso  (miso),
      .byt   (byt_if.slave)
   );

   // bytes to register accesses
   spi_cmd_decoder u_decoder (
      .clk   (clk),
      .rst_n (rst_n),
      .byt   (byt_if.decoder),
      .acc   (acc_if.master)
   );

   // config outputs
   reg_bank u_bank (
      .clk        (clk),
      .rst_n      (rst_n),
      .acc        (acc_if.bank),
      .cfg_regs   (cfg_regs),
      .cfg_update (cfg_update)
   );

endmodule

/* hw/spi_slave.sv */
`timescale 1ns/10ps
`include "spi_cmd_settings.svh"

module spi_slave (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     sck,
   input  logic     mosi,
   input  logic     ssel,
   output logic     miso,
   spi_byte_if.slave byt
);
   import spi_cmd_pkg::*;

   logic [2:0] sck_r;
   logic [2:0] ssel_r;
   logic [1:0] mosi_r;
   logic       sck_rise;
   logic       sck_fall;
   logic       ssel_active;
   logic       msg_start;
   logic       msg_end;
   logic [2:0] bit_cnt;
   spi_byte_t  rx_shift;
   spi_byte_t  tx_shift;
   byte_cnt_t  byte_cnt_q;
   logic       byte_rcvd;
   logic       cmd_ready_r2;
   logic       param_ready_r2;
   logic       cmd_ready_q;
   logic       param_ready_q;

   //////////////////////////////////////////////////
   // pin synchronizers
   //////////////////////////////////////////////////

   // sck idles low in mode 0, ssel idles high
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sck_r  <= 3'b000;
         ssel_r <= 3'b111;
         mosi_r <= 2'b00;
      end else begin
         sck_r  <= {sck_r[1:0], sck};
         ssel_r <= {ssel_r[1:0], ssel};
         mosi_r <= {mosi_r[0], mosi};
      end
   end

   // edges taken from the two oldest stages
   assign sck_rise = ~sck_r[2] & sck_r[1];
   assign sck_fall = sck_r[2] & ~sck_r[1];

   // ssel is active low
   assign ssel_active = ~ssel_r[1];
   assign msg_start   = ssel_r[2] & ~ssel_r[1];
   assign msg_end     = ~ssel_r[2] & ssel_r[1];

   //////////////////////////////////////////////////
   // receive side
   //////////////////////////////////////////////////

   // bit position within the current byte
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bit_cnt <= 3'd0;
      end else if (!ssel_active) begin
         bit_cnt <= 3'd0;
      end else if (sck_rise) begin
         bit_cnt <= bit_cnt + 3'd1;
      end
   end

   // msb first
   always_ff @(posedge clk) begin
      if (ssel_active && sck_rise) begin
         rx_shift <= {rx_shift[6:0], mosi_r[1]};
      end
   end

   // eighth rise closes the byte
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         byte_rcvd <= 1'b0;
      end else begin
         byte_rcvd <= ssel_active && sck_rise && (bit_cnt == 3'd7);
      end
   end

   // held at zero between messages
   // saturates so an overlong message never looks like a new command
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         byte_cnt_q <= '0;
      end else if (!ssel_active) begin
         byte_cnt_q <= '0;
      end else if (byte_rcvd && (byte_cnt_q != '1)) begin
         byte_cnt_q <= byte_cnt_q + byte_cnt_t'(1);
      end
   end

   // split by byte index, then one more stage
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cmd_ready_r2   <= 1'b0;
         param_ready_r2 <= 1'b0;
         cmd_ready_q    <= 1'b0;
         param_ready_q  <= 1'b0;
      end else begin
         cmd_ready_r2   <= byte_rcvd && (byte_cnt_q == '0);
         param_ready_r2 <= byte_rcvd && (byte_cnt_q != '0);
         cmd_ready_q    <= cmd_ready_r2;
         param_ready_q  <= param_ready_r2;
      end
   end

   assign byt.cmd_ready   = cmd_ready_q;
   assign byt.param_ready = param_ready_q;
   // shifter is stable until the next byte's first rise
   assign byt.rx_data     = rx_shift;
   assign byt.byte_cnt    = byte_cnt_q;
   assign byt.start_msg   = msg_start;
   assign byt.end_msg     = msg_end;

   //////////////////////////////////////////////////
   // transmit side
   //////////////////////////////////////////////////

   // dummy byte goes out first
   // tx_data sampled on the fall that opens each later byte
   always_ff @(posedge clk) begin
      if (ssel_active) begin
         if (msg_start) begin
            tx_shift <= `SPI_DUMMY_BYTE;
         end else if (sck_fall) begin
            if (bit_cnt == 3'd0) begin
               tx_shift <= byt.tx_data;
            end else begin
               tx_shift <= {tx_shift[6:0], 1'b0};
            end
         end
      end
   end

   // high while deselected
   assign miso = ssel_active ? tx_shift[7] : 1'b1;

endmodule

/* include/spi_cmd_settings.svh */
`ifndef SPI_CMD_SETTINGS_SVH
`define SPI_CMD_SETTINGS_SVH

// reply bytes on miso
// first byte of every reply
`define SPI_DUMMY_BYTE 8'h5A
// filler when nothing is read back
`define SPI_IDLE_BYTE 8'hFF

// command high nibble
`define SPI_OP_READ 4'h4
`define SPI_OP_WRITE 4'h8

// register bank size
// matches the 3-bit address in the command
`define SPI_NUM_REGS 8

// read-only message counter location
`define SPI_STATUS_ADDR 3'd7

// byte index within one message
`define SPI_BYTE_CNT_W 16

`endif

/* project.f */
+incdir+include
hw/spi_cmd_pkg.sv
hw/spi_byte_if.sv
hw/reg_access_if.sv
hw/spi_slave.sv
hw/spi_cmd_decoder.sv
hw/reg_bank.sv
hw/spi_cmd_top.sv
verif/tb_spi_cmd.sv

/* verif/spi_cmd_golden.txt */
# len, mosi bytes 0..7, expected miso bytes 0..7 (byte 1 unchecked), expected cfg_regs
# all hex except len; bytes past len are padding; cfg_regs is reg7 down to reg0
4 80 11 22 33 00 00 00 00 5A FF FF FF 00 00 00 00 0100000000332211
6 85 A5 B6 C7 D8 E9 00 00 5A FF FF FF FF FF 00 00 02B6A5000033E9D8
8 46 00 00 00 00 00 00 00 5A FF B6 02 D8 E9 33 00 03B6A5000033E9D8
3 23 44 55 00 00 00 00 00 5A FF FF 00 00 00 00 00 04B6A5000033E9D8
2 87 99 00 00 00 00 00 00 5A FF 00 00 00 00 00 00 05B6A5000033E9D8
1 40 00 00 00 00 00 00 00 5A 00 00 00 00 00 00 00 06B6A5000033E9D8
8 82 01 02 03 04 05 06 07 5A FF FF FF FF FF FF FF 070504030201E907
8 47 00 00 00 00 00 00 00 5A FF 07 07 E9 01 02 03 080504030201E907
5 40 00 00 00 00 00 00 00 5A FF 07 E9 01 00 00 00 090504030201E907
8 C1 12 34 56 78 9A BC DE 5A FF FF FF FF FF FF FF 0A0504030201E907
3 8F AA BB 00 00 00 00 00 5A FF FF 00 00 00 00 00 0B0504030201E9BB
4 49 00 00 00 00 00 00 00 5A FF E9 01 00 00 00 00 0C0504030201E9BB
8 83 10 20 30 40 50 60 70 5A FF FF FF FF FF FF FF 0D40302010017060
8 43 00 00 00 00 00 00 00 5A FF 10 20 30 40 0D 60 0E40302010017060
2 45 00 00 00 00 00 00 00 5A FF 00 00 00 00 00 00 0F40302010017060

/* verif/tb_spi_cmd.sv */
`timescale 1ns/10ps
`include "spi_cmd_settings.svh"

module tb_spi_cmd;
   import spi_cmd_pkg::*;

   logic        clk;
   logic        rst_n;
   logic        sck;
   logic        mosi;
   logic        ssel;
   logic        miso;
   logic [63:0] cfg_regs;
   logic        cfg_update;

   // fields of one golden line
   int          msg_len;
   spi_byte_t   mosi_bytes [8];
   spi_byte_t   gold_miso [8];
   logic [63:0] gold_regs;
   // what came back on miso
   spi_byte_t   miso_bytes [8];
   // bank model, counter lives in slot 7
   spi_byte_t   model_regs [8];
   int          update_cnt = 0;
   logic [31:0] rng_state;

   spi_cmd_top DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .sck        (sck),
      .mosi       (mosi),
      .ssel       (ssel),
      .miso       (miso),
      .cfg_regs   (cfg_regs),
      .cfg_update (cfg_update)
   );

   // 20 ns period
   always #10 clk = ~clk;

   // update pulses, counted on the quiet edge
   always @(negedge clk) begin
      if (cfg_update) begin
         update_cnt <= update_cnt + 1;
      end
   end

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic fail_test(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_byte(input string name, input spi_byte_t exp,
                             input spi_byte_t act);
      if (act !== exp) begin
         fail_test($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_regs(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
      if (act !== exp) begin
         fail_test($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
      end
   endtask

   task automatic check_update(input string name, input int exp, input int act);
      if (act != exp) begin
         fail_test($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
      end
   endtask

   // inputs always move just after a falling clk edge
   task automatic wait_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
      end
   endtask

   task automatic wait_miso_idle();
      int n;
      n = 0;
      while (miso !== 1'b1) begin
         if (n == 20) begin
            fail_test("timeout: miso did not go high after ssel was raised");
         end else begin
            n++;
            @(negedge clk);
         end
      end
   endtask

   //////////////////////////////////////////////////
   // spi master, mode 0, msb first
   //////////////////////////////////////////////////

   task automatic spi_transfer(input int half);
      spi_byte_t rx;
      ssel = 1'b0;
      wait_cycles(half);
      for (int b = 0; b < msg_len; b++) begin
         for (int i = 7; i >= 0; i--) begin
            mosi = mosi_bytes[b][i];
            wait_cycles(half);
            // slave shifted on the last fall, miso settled
            rx  = {rx[6:0], miso};
            sck = 1'b1;
            wait_cycles(half);
            sck = 1'b0;
         end
         miso_bytes[b] = rx;
      end
      wait_cycles(half);
      ssel = 1'b1;
      mosi = 1'b0;
   endtask

   task automatic run_message(input int idx);
      int          half;
      int          gap;
      int          upd_start;
      int          exp_upd;
      string       name;
      spi_byte_t   cmd;
      reg_addr_t   addr;
      spi_byte_t   exp_miso [8];
      logic [63:0] model_cfg;

      cmd       = mosi_bytes[0];
      rng_state = xorshift32(rng_state);
      half      = 4 + int'(rng_state[1:0]);
      rng_state = xorshift32(rng_state);
      gap       = 4 + int'(rng_state[2:0]);

      // reply from the bank as it stood before this message
      exp_miso[0] = `SPI_DUMMY_BYTE;
      exp_miso[1] = `SPI_IDLE_BYTE;
      for (int k = 2; k < 8; k++) begin
         addr = reg_addr_t'(cmd[2:0] + k - 2);
         if (cmd[7:4] == `SPI_OP_READ) begin
            exp_miso[k] = model_regs[addr];
         end else begin
            exp_miso[k] = `SPI_IDLE_BYTE;
         end
      end

      upd_start = update_cnt;
      spi_transfer(half);
      wait_miso_idle();
      // counter bumps a few clk after ssel rises
      wait_cycles(6);

      // byte 1 is never ready in time
      for (int k = 0; k < msg_len; k++) begin
         if (k != 1) begin
            name = $sformatf("msg %0d miso byte %0d", idx, k);
            check_byte(name, gold_miso[k], miso_bytes[k]);
            check_byte({name, " vs model"}, exp_miso[k], miso_bytes[k]);
         end
      end

      // writes walk up from n, slot 7 drops them
      exp_upd = 0;
      if (cmd[7:4] == `SPI_OP_WRITE) begin
         for (int k = 1; k < msg_len; k++) begin
            addr = reg_addr_t'(cmd[2:0] + k - 1);
            if (addr != `SPI_STATUS_ADDR) begin
               model_regs[addr] = mosi_bytes[k];
               exp_upd++;
            end
         end
      end
      // every message counts, known opcode or not
      model_regs[`SPI_STATUS_ADDR] = model_regs[`SPI_STATUS_ADDR] + 8'd1;
      for (int i = 0; i < 8; i++) begin
         model_cfg[8*i +: 8] = model_regs[i];
      end

      check_regs($sformatf("msg %0d cfg_regs", idx), gold_regs, cfg_regs);
      check_regs($sformatf("msg %0d cfg_regs vs model", idx), model_cfg, cfg_regs);
      check_update($sformatf("msg %0d cfg_update count", idx), exp_upd,
                   update_cnt - upd_start);
      wait_cycles(gap);
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////

   initial begin
      int fd;
      int c;
      int n;
      int idx;

      clk       = 1'b0;
      rst_n     = 1'b0;
      sck       = 1'b0;
      mosi      = 1'b0;
      ssel      = 1'b1;
      rng_state = 32'h4a39_e753;
      for (int i = 0; i < 8; i++) begin
         model_regs[i] = '0;
      end
      wait_cycles(3);
      rst_n = 1'b1;
      wait_cycles(4);

      // idle after reset
      check_regs("reset cfg_regs", '0, cfg_regs);
      check_update("reset cfg_update count", 0, update_cnt);
      if (miso !== 1'b1) begin
         fail_test("miso is not high while ssel is high after reset");
      end

      fd = $fopen("verif/spi_cmd_golden.txt", "r");
      if (fd == 0) begin
         fail_test("could not open verif/spi_cmd_golden.txt");
      end
      // one digit length opens a data line, # opens a comment
      idx = 0;
      c   = $fgetc(fd);
      while (c != -1) begin
         if (c == int'("#")) begin
            while (c != -1 && c != int'("\n")) begin
               c = $fgetc(fd);
            end
         end else if (c >= int'("1") && c <= int'("8")) begin
            msg_len = c - int'("0");
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        mosi_bytes[0], mosi_bytes[1], mosi_bytes[2], mosi_bytes[3],
                        mosi_bytes[4], mosi_bytes[5], mosi_bytes[6], mosi_bytes[7],
                        gold_miso[0], gold_miso[1], gold_miso[2], gold_miso[3],
                        gold_miso[4], gold_miso[5], gold_miso[6], gold_miso[7],
                        gold_regs);
            if (n != 17) begin
               fail_test($sformatf("golden line %0d has missing fields", idx));
            end
            run_message(idx);
            idx++;
         end else if (c != int'(" ") && c != int'("\n") && c != int'("\r")
                      && c != int'("\t")) begin
            fail_test("golden file holds a line that is not a message");
         end
         c = $fgetc(fd);
      end
      $fclose(fd);

      if (idx == 0) begin
         fail_test("golden file held no messages");
      end else begin
         $display("*** TEST PASSED ***");
         $finish;
      end
   end

endmodule
